/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [4:0] reg_addr_t;

  // Major opcodes of the supported instruction classes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // Encoded as funct3 of the load and store instructions
  typedef enum logic [2:0] {
    MEM_BYTE   = 3'b000,
    MEM_HALF   = 3'b001,
    MEM_WORD   = 3'b010,
    MEM_BYTE_U = 3'b100,
    MEM_HALF_U = 3'b101
  } mem_size_e;

  typedef struct packed {
    alu_op_e             alu_op;
    logic                use_imm;
    logic [xlen-1:0]     imm;
    reg_addr_t           rs1;
    reg_addr_t           rs2;
    reg_addr_t           rd;
    logic                is_load;
    logic                is_store;
    mem_size_e           mem_size;
  } dec_instr_t;

  typedef struct packed {
    dec_instr_t          dec;
    logic [xlen-1:0]     rs1_val;
    logic [xlen-1:0]     rs2_val;
  } opf_instr_t;

  typedef struct packed {
    logic                valid;
    reg_addr_t           rd;
    logic [xlen-1:0]     data;
  } wb_result_t;

endpackage

`default_nettype wire

/* hdl/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode #(
  parameter int NUM_REGS = 32
) (
  input  wire                             clk_i,
  input  wire                             rst_i,
  input  wire  [rv_core_pkg::xlen-1:0]    inst_i,
  input  wire                             inst_valid_i,
  output logic                            inst_ready_o,
  output rv_core_pkg::dec_instr_t         dec_o,
  output logic                            dec_valid_o,
  input  wire                             dec_ready_i
);

  rv_core_pkg::opcode_e       opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [31:0]                imm_i;
  logic [31:0]                imm_s;
  logic [31:0]                imm_u;
  logic                       legal;
  rv_core_pkg::dec_instr_t    dec_d;
  rv_core_pkg::dec_instr_t    dec_q;
  logic                       dec_valid_q;

  // OP and OP-IMM share funct3; only the register form has SUB
  function automatic rv_core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                           input logic alt,
                                                           input logic reg_form);
    case (f3)
      3'b000:  return (alt && reg_form) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  return rv_core_pkg::ALU_SLL;
      3'b010:  return rv_core_pkg::ALU_SLT;
      3'b011:  return rv_core_pkg::ALU_SLTU;
      3'b100:  return rv_core_pkg::ALU_XOR;
      3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  return rv_core_pkg::ALU_OR;
      default: return rv_core_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode = rv_core_pkg::opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_u  = {inst_i[31:12], 12'b0};

  //////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////

  always_comb begin
    dec_d          = '0;
    dec_d.alu_op   = rv_core_pkg::ALU_ADD;
    dec_d.use_imm  = 1'b1;
    dec_d.imm      = imm_i;
    dec_d.rs1      = inst_i[19:15];
    dec_d.rs2      = inst_i[24:20];
    dec_d.rd       = inst_i[11:7];
    dec_d.mem_size = rv_core_pkg::mem_size_e'(funct3);
    legal          = 1'b1;
    case (opcode)
      rv_core_pkg::OPC_LUI: begin
        dec_d.alu_op = rv_core_pkg::ALU_PASS_B;
        dec_d.imm    = imm_u;
        dec_d.rs1    = '0;
        dec_d.rs2    = '0;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        dec_d.alu_op = alu_from_funct3(funct3, funct7[5], 1'b0);
        dec_d.rs2    = '0;
      end
      rv_core_pkg::OPC_OP: begin
        dec_d.alu_op  = alu_from_funct3(funct3, funct7[5], 1'b1);
        dec_d.use_imm = 1'b0;
      end
      rv_core_pkg::OPC_LOAD: begin
        dec_d.is_load = 1'b1;
        dec_d.rs2     = '0;
        legal         = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
      end
      rv_core_pkg::OPC_STORE: begin
        dec_d.is_store = 1'b1;
        dec_d.imm      = imm_s;
        dec_d.rd       = '0;
        legal          = !funct3[2] && (funct3 != 3'b011);
      end
      default: legal = 1'b0;
    endcase
    // Registers past the end of a reduced file make the instruction illegal
    if (dec_d.rd >= NUM_REGS || dec_d.rs1 >= NUM_REGS || dec_d.rs2 >= NUM_REGS) begin
      legal = 1'b0;
    end
    // Anything illegal retires as an add with no destination
    if (!legal) begin
      dec_d.rd       = '0;
      dec_d.rs1      = '0;
      dec_d.rs2      = '0;
      dec_d.is_load  = 1'b0;
      dec_d.is_store = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  assign inst_ready_o = !dec_valid_q || dec_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_valid_q <= 1'b0;
    end else if (inst_ready_o) begin
      dec_valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inst_valid_i && inst_ready_o) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = dec_valid_q;

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile #(
  parameter int NUM_REGS = 32
) (
  input  wire                           clk_i,
  input  wire rv_core_pkg::reg_addr_t   rs1_addr_i,
  input  wire rv_core_pkg::reg_addr_t   rs2_addr_i,
  output logic [rv_core_pkg::xlen-1:0]  rs1_data_o,
  output logic [rv_core_pkg::xlen-1:0]  rs2_data_o,
  input  wire rv_core_pkg::wb_result_t  wr_i
);

  localparam int AW = $clog2(NUM_REGS);

  logic [rv_core_pkg::xlen-1:0] regs [NUM_REGS];
  logic                         wr_en;

  assign wr_en = wr_i.valid && (wr_i.rd != '0);

  // x0 reads as zero, a same-cycle write is passed straight through
  function automatic logic [rv_core_pkg::xlen-1:0] read_port(
      input rv_core_pkg::reg_addr_t addr,
      input logic [rv_core_pkg::xlen-1:0] stored);
    if (addr == '0) begin
      return '0;
    end
    if (wr_en && (wr_i.rd == addr)) begin
      return wr_i.data;
    end
    return stored;
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i, regs[rs1_addr_i[AW-1:0]]);
    rs2_data_o = read_port(rs2_addr_i, regs[rs2_addr_i[AW-1:0]]);
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs[wr_i.rd[AW-1:0]] <= wr_i.data;
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_operand_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_operand_fetch (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire rv_core_pkg::dec_instr_t  dec_i,
  input  wire                           dec_valid_i,
  output logic                          dec_ready_o,
  output rv_core_pkg::reg_addr_t        rs1_addr_o,
  output rv_core_pkg::reg_addr_t        rs2_addr_o,
  input  wire [rv_core_pkg::xlen-1:0]   rs1_data_i,
  input  wire [rv_core_pkg::xlen-1:0]   rs2_data_i,
  output rv_core_pkg::opf_instr_t       opf_o,
  output logic                          opf_valid_o,
  input  wire                           opf_accept_i
);

  rv_core_pkg::opf_instr_t opf_q;
  logic                    opf_valid_q;
  logic                    advance;

  // Register file is addressed straight from the decode record
  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  assign dec_ready_o = !opf_valid_q || opf_accept_i;
  assign advance     = dec_valid_i && dec_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opf_valid_q <= 1'b0;
    end else if (dec_ready_o) begin
      opf_valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      opf_q.dec     <= dec_i;
      opf_q.rs1_val <= rs1_data_i;
      opf_q.rs2_val <= rs2_data_i;
    end
  end

  assign opf_o       = opf_q;
  assign opf_valid_o = opf_valid_q;

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  wire rv_core_pkg::alu_op_e     op_i,
  input  wire [rv_core_pkg::xlen-1:0]   a_i,
  input  wire [rv_core_pkg::xlen-1:0]   b_i,
  output logic [rv_core_pkg::xlen-1:0]  result_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
      rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
      rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
      rv_core_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      rv_core_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
      rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
      rv_core_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
      rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
      rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
      // LUI carries its upper immediate on operand 2
      rv_core_pkg::ALU_PASS_B: result_o = b_i;
      default:                 result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           start_i,
  input  wire [rv_core_pkg::xlen-1:0]   addr_i,
  input  wire [rv_core_pkg::xlen-1:0]   store_data_i,
  input  wire rv_core_pkg::mem_size_e   size_i,
  input  wire                           write_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          load_ok_o,
  output logic [rv_core_pkg::xlen-1:0]  load_data_o,
  input  wire [31:0]                    wb_dat_i,
  output logic [31:0]                   wb_dat_o,
  output logic [29:0]                   wb_adr_o,
  output logic [3:0]                    wb_sel_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  input  wire                           wb_ack_i,
  input  wire                           wb_err_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ACCESS
  } state_e;

  state_e      state_q;
  logic        launch;
  logic        bus_end;
  logic [1:0]  offset_q;
  logic [3:0]  sel_d;
  logic [31:0] lane_data;

  assign launch  = (state_q == ST_IDLE) && start_i;
  assign bus_end = (state_q == ST_ACCESS) && (wb_ack_i || wb_err_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else if (launch) begin
      state_q <= ST_ACCESS;
    end else if (bus_end) begin
      state_q <= ST_IDLE;
    end
  end

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  always_comb begin
    case (size_i)
      rv_core_pkg::MEM_BYTE, rv_core_pkg::MEM_BYTE_U: sel_d = 4'b0001 << addr_i[1:0];
      rv_core_pkg::MEM_HALF, rv_core_pkg::MEM_HALF_U: sel_d = 4'b0011 << addr_i[1:0];
      default:                                        sel_d = 4'b1111;
    endcase
  end

  // Held steady for the whole access
  always_ff @(posedge clk_i) begin
    if (launch) begin
      wb_adr_o <= addr_i[31:2];
      wb_sel_o <= sel_d;
      wb_dat_o <= store_data_i << {addr_i[1:0], 3'b000};
      offset_q <= addr_i[1:0];
    end
  end

  assign busy_o   = (state_q == ST_ACCESS);
  assign wb_cyc_o = busy_o;
  assign wb_stb_o = busy_o;
  assign wb_we_o  = busy_o && write_i;

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  assign lane_data = wb_dat_i >> {offset_q, 3'b000};

  always_comb begin
    case (size_i)
      rv_core_pkg::MEM_BYTE:   load_data_o = {{24{lane_data[7]}}, lane_data[7:0]};
      rv_core_pkg::MEM_BYTE_U: load_data_o = {24'b0, lane_data[7:0]};
      rv_core_pkg::MEM_HALF:   load_data_o = {{16{lane_data[15]}}, lane_data[15:0]};
      rv_core_pkg::MEM_HALF_U: load_data_o = {16'b0, lane_data[15:0]};
      default:                 load_data_o = lane_data;
    endcase
  end

  // An error ends the access without data
  assign done_o    = bus_end;
  assign load_ok_o = bus_end && wb_ack_i && !wb_err_i && !write_i;

endmodule

`default_nettype wire

/* hdl/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire rv_core_pkg::opf_instr_t  opf_i,
  input  wire                           opf_valid_i,
  output logic                          opf_accept_o,
  output rv_core_pkg::wb_result_t       result_o,
  input  wire [31:0]                    wb_dat_i,
  output logic [31:0]                   wb_dat_o,
  output logic [29:0]                   wb_adr_o,
  output logic [3:0]                    wb_sel_o,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  input  wire                           wb_ack_i,
  input  wire                           wb_err_i
);

  rv_core_pkg::wb_result_t      result_d;
  rv_core_pkg::wb_result_t      result_q;
  logic [rv_core_pkg::xlen-1:0] op_a;
  logic [rv_core_pkg::xlen-1:0] op_b;
  logic [rv_core_pkg::xlen-1:0] rs2_fwd;
  logic [rv_core_pkg::xlen-1:0] alu_result;
  logic [rv_core_pkg::xlen-1:0] load_data;
  logic                         fwd_rs1;
  logic                         fwd_rs2;
  logic                         is_mem;
  logic                         lsu_start;
  logic                         lsu_busy;
  logic                         lsu_done;
  logic                         lsu_load_ok;

  // Result register bypass
  assign fwd_rs1 = result_q.valid && (result_q.rd != '0) && (result_q.rd == opf_i.dec.rs1);
  assign fwd_rs2 = result_q.valid && (result_q.rd != '0) && (result_q.rd == opf_i.dec.rs2);
  assign op_a    = fwd_rs1 ? result_q.data : opf_i.rs1_val;
  assign rs2_fwd = fwd_rs2 ? result_q.data : opf_i.rs2_val;
  assign op_b    = opf_i.dec.use_imm ? opf_i.dec.imm : rs2_fwd;

  // Memory ops hold until the bus access ends
  assign is_mem       = opf_i.dec.is_load || opf_i.dec.is_store;
  assign lsu_start    = opf_valid_i && is_mem && !lsu_busy;
  assign opf_accept_o = !is_mem || lsu_done;

  // Loads and stores decode as ADD with their offset, so this is also the address
  rv_alu u_alu (
    .op_i     (opf_i.dec.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  rv_lsu u_lsu (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (lsu_start),
    .addr_i       (alu_result),
    .store_data_i (rs2_fwd),
    .size_i       (opf_i.dec.mem_size),
    .write_i      (opf_i.dec.is_store),
    .busy_o       (lsu_busy),
    .done_o       (lsu_done),
    .load_ok_o    (lsu_load_ok),
    .load_data_o  (load_data),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_adr_o     (wb_adr_o),
    .wb_sel_o     (wb_sel_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i)
  );

  always_comb begin
    result_d.valid = (opf_valid_i && !is_mem) || lsu_load_ok;
    result_d.rd    = opf_i.dec.rd;
    result_d.data  = lsu_load_ok ? load_data : alu_result;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_q.valid <= 1'b0;
    end else begin
      result_q.valid <= result_d.valid;
    end
    result_q.rd   <= result_d.rd;
    result_q.data <= result_d.data;
  end

  assign result_o = result_q;

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int NUM_REGS = 32
) (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire  [31:0] inst_i,
  input  wire         inst_valid_i,
  output logic        inst_ready_o,
  input  wire  [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic [29:0] wb_adr_o,
  output logic [3:0]  wb_sel_o,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  input  wire         wb_ack_i,
  input  wire         wb_err_i
);

  rv_core_pkg::dec_instr_t      dec;
  logic                         dec_valid;
  logic                         dec_ready;
  rv_core_pkg::reg_addr_t       rs1_addr;
  rv_core_pkg::reg_addr_t       rs2_addr;
  logic [rv_core_pkg::xlen-1:0] rs1_data;
  logic [rv_core_pkg::xlen-1:0] rs2_data;
  rv_core_pkg::opf_instr_t      opf;
  logic                         opf_valid;
  logic                         opf_accept;
  rv_core_pkg::wb_result_t      result;

  rv_decode #(
    .NUM_REGS (NUM_REGS)
  ) u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .dec_o        (dec),
    .dec_valid_o  (dec_valid),
    .dec_ready_i  (dec_ready)
  );

  rv_regfile #(
    .NUM_REGS (NUM_REGS)
  ) u_regfile (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_i       (result)
  );

  rv_operand_fetch u_operand_fetch (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .dec_i        (dec),
    .dec_valid_i  (dec_valid),
    .dec_ready_o  (dec_ready),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .opf_o        (opf),
    .opf_valid_o  (opf_valid),
    .opf_accept_i (opf_accept)
  );

  rv_execute u_execute (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .opf_i        (opf),
    .opf_valid_i  (opf_valid),
    .opf_accept_o (opf_accept),
    .result_o     (result),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_adr_o     (wb_adr_o),
    .wb_sel_o     (wb_sel_o),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_ack_i     (wb_ack_i),
    .wb_err_i     (wb_err_i)
  );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Synchronous reset held for the first 10 rising edges
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  logic        clk_i;
  logic        rst_i;
  logic [31:0] inst_i;
  logic        inst_valid_i;
  logic        inst_ready_o;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic [29:0] wb_adr_o;
  logic [3:0]  wb_sel_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic        wb_ack_i;
  logic        wb_err_i;

  integer      seed = 32'h04c9ea16;
  int          err_count = 0;
  string       cur_test;
  logic [31:0] mem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] rr [32];
  logic [3:0]  sel_log[$];
  logic [3:0]  exp_sel[$];
  int          store_acks;
  int          stores_sent;
  logic        in_access = 1'b0;
  int          delay = 0;

  tb_clock_gen u_clock_gen (.clk_o(clk_i), .rst_o(rst_i));

  rv_core #(.NUM_REGS(32)) dut_i (
    .clk_i(clk_i), .rst_i(rst_i), .inst_i(inst_i), .inst_valid_i(inst_valid_i),
    .inst_ready_o(inst_ready_o), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
    .wb_adr_o(wb_adr_o), .wb_sel_o(wb_sel_o), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o),
    .wb_we_o(wb_we_o), .wb_ack_i(wb_ack_i), .wb_err_i(wb_err_i)
  );

  function automatic logic [31:0] fill(input int i);
    return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] ^ 8'hc3};
  endfunction

  //////////////////////////////////////////////////
  // Wishbone slave model
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    wb_ack_i <= 1'b0;
    wb_err_i <= 1'b0;
    if (wb_cyc_o && wb_stb_o && !wb_ack_i && !wb_err_i) begin
      if (!in_access) begin
        in_access = 1'b1;
        delay = $unsigned($random(seed)) % 4;
      end
      if (delay == 0) begin
        in_access = 1'b0;
        if (wb_adr_o >= 256) begin
          wb_err_i <= 1'b1;
        end else begin
          wb_ack_i <= 1'b1;
          if (wb_we_o) begin
            for (int b = 0; b < 4; b++) begin
              if (wb_sel_o[b]) mem[wb_adr_o[7:0]][8*b +: 8] = wb_dat_o[8*b +: 8];
            end
            sel_log.push_back(wb_sel_o);
            store_acks++;
          end else begin
            wb_dat_i <= mem[wb_adr_o[7:0]];
          end
        end
      end else begin
        delay = delay - 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Instruction feed and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic send(input logic [31:0] instr);
    int  n;
    bit  ok;
    n = 0;
    ok = 0;
    inst_i <= instr;
    inst_valid_i <= 1'b1;
    while (!ok && n < 200) begin
      @(negedge clk_i);
      ok = inst_ready_o;
      @(posedge clk_i);
      n++;
    end
    assert (ok) else begin
      $display("%s: instruction port never became ready", cur_test);
      err_count++;
    end
  endtask

  task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
    send({imm, rd, 7'h37});
    if (rd != 0) rr[rd] = {imm, 12'b0};
  endtask

  task automatic op_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic [31:0] v;
    v = alu_ref(f3, (f3 == 3'd5) && imm[10], rr[rs1], {{20{imm[11]}}, imm});
    send({imm, rs1, f3, rd, 7'h13});
    if (rd != 0) rr[rd] = v;
  endtask

  task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] v;
    v = alu_ref(f3, alt, rr[rs1], rr[rs2]);
    send({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33});
    if (rd != 0) rr[rd] = v;
  endtask

  task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] v;
    a = rr[rs1] + {{20{imm[11]}}, imm};
    send({imm, rs1, f3, rd, 7'h03});
    // An erroring access leaves the destination alone
    if (a[31:2] < 256) begin
      w = ref_mem[a[9:2]] >> (8 * a[1:0]);
      case (f3)
        3'd0: v = {{24{w[7]}}, w[7:0]};
        3'd1: v = {{16{w[15]}}, w[15:0]};
        3'd4: v = {24'b0, w[7:0]};
        3'd5: v = {16'b0, w[15:0]};
        default: v = w;
      endcase
      if (rd != 0) rr[rd] = v;
    end
  endtask

  task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [4:0] rs1,
                       input logic [11:0] imm);
    logic [31:0] a;
    logic [3:0]  sel;
    a = rr[rs1] + {{20{imm[11]}}, imm};
    send({imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23});
    if (a[31:2] < 256) begin
      sel = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
      sel = sel << a[1:0];
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) ref_mem[a[9:2]][8*b +: 8] = rr[rs2][8*(b - a[1:0]) +: 8];
      end
      exp_sel.push_back(sel);
      stores_sent++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    sel_log.delete();
    exp_sel.delete();
    store_acks = 0;
    stores_sent = 0;
  endtask

  // Idle handshake and bus outputs right after reset
  task automatic check_reset_outputs();
    cur_test = "reset";
    assert (inst_ready_o === 1'b1) else begin
      $display("Mismatch %s: expected inst_ready_o 1 actual %b", cur_test, inst_ready_o);
      err_count++;
    end
    assert ({wb_cyc_o, wb_stb_o, wb_we_o} === 3'b000) else begin
      $display("Mismatch %s: expected cyc stb we 000 actual %b", cur_test,
               {wb_cyc_o, wb_stb_o, wb_we_o});
      err_count++;
    end
  endtask

  // Waits until every in-range store is acknowledged and the bus is idle,
  // then compares the bus and memory state
  task automatic check_state();
    int n;
    bit idle;
    inst_valid_i <= 1'b0;
    n = 0;
    idle = 0;
    while (!idle && n < 500) begin
      @(posedge clk_i);
      idle = (store_acks >= stores_sent) && !wb_cyc_o;
      n++;
    end
    assert (idle) else begin
      $display("%s: stores never completed on the bus", cur_test);
      err_count++;
    end
    assert (store_acks == stores_sent) else begin
      $display("Mismatch %s: expected %0d stores actual %0d", cur_test, stores_sent, store_acks);
      err_count++;
    end
    for (int i = 0; i < exp_sel.size() && i < sel_log.size(); i++) begin
      assert (sel_log[i] == exp_sel[i]) else begin
        $display("Mismatch %s: expected sel %b actual %b", cur_test, exp_sel[i], sel_log[i]);
        err_count++;
      end
    end
    for (int i = 0; i < 256; i++) begin
      assert (mem[i] == ref_mem[i]) else begin
        $display("Mismatch %s: expected %h actual %h at word %0d", cur_test, ref_mem[i],
                 mem[i], i);
        err_count++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic alu_test();
    logic [11:0] off;
    start_test("alu");
    lui(5'd1, 20'h80001);
    op_imm(3'd0, 5'd1, 5'd1, 12'h234);
    op_imm(3'd0, 5'd2, 5'd0, 12'hff9);
    op_imm(3'd0, 5'd3, 5'd0, 12'h005);
    off = 12'h000;
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          op_rr(f[2:0], alt[0], 5'd10, 5'd1, 5'd2);
          store(3'd2, 5'd10, 5'd0, off);
          op_rr(f[2:0], alt[0], 5'd10, 5'd2, 5'd3);
          store(3'd2, 5'd10, 5'd0, off + 12'd4);
          op_imm(f[2:0], 5'd11, 5'd1, (f == 1 || f == 5) ? {1'b0, alt[0], 10'd3} : 12'hff9);
          store(3'd2, 5'd11, 5'd0, off + 12'd8);
          off = off + 12'd12;
        end
      end
    end
    check_state();
  endtask

  task automatic dependency_test();
    start_test("dependency");
    op_imm(3'd0, 5'd5, 5'd0, 12'h003);
    op_imm(3'd0, 5'd6, 5'd5, 12'h7f4);
    for (int r = 7; r < 21; r++) begin
      op_rr(r % 8, (r % 8 == 0 || r % 8 == 5) && r[3], r[4:0], r - 1, r - 2);
    end
    store(3'd2, 5'd20, 5'd0, 12'h100);
    for (int r = 5; r < 21; r++) begin
      store(3'd2, r[4:0], 5'd0, 12'h104 + 4 * r);
    end
    check_state();
  endtask

  task automatic narrow_test();
    start_test("narrow");
    op_imm(3'd0, 5'd12, 5'd0, 12'h200);
    lui(5'd13, 20'h8badf);
    op_imm(3'd0, 5'd13, 5'd13, 12'h7ee);
    op_imm(3'd0, 5'd14, 5'd0, 12'h981);
    for (int o = 0; o < 4; o++) begin
      store(3'd0, (o % 2) ? 5'd14 : 5'd13, 5'd12, o);
    end
    store(3'd1, 5'd14, 5'd12, 12'h004);
    store(3'd1, 5'd13, 5'd12, 12'h006);
    for (int o = 0; o < 4; o++) begin
      load(3'd0, 5'd15, 5'd12, o);
      store(3'd2, 5'd15, 5'd12, 12'h080 + 8 * o);
      load(3'd4, 5'd15, 5'd12, o);
      store(3'd2, 5'd15, 5'd12, 12'h084 + 8 * o);
    end
    for (int o = 0; o < 4; o += 2) begin
      load(3'd1, 5'd15, 5'd12, 12'h004 + o);
      store(3'd2, 5'd15, 5'd12, 12'h0a0 + 4 * o);
      load(3'd5, 5'd15, 5'd12, 12'h004 + o);
      store(3'd2, 5'd15, 5'd12, 12'h0a4 + 4 * o);
    end
    load(3'd2, 5'd15, 5'd12, 12'h004);
    store(3'd2, 5'd15, 5'd12, 12'h0b0);
    check_state();
  endtask

  task automatic stall_test();
    start_test("stall");
    op_imm(3'd0, 5'd16, 5'd0, 12'h011);
    for (int i = 0; i < 24; i++) begin
      op_imm(3'd0, 5'd16, 5'd16, 3 * i);
      store(3'd2, 5'd16, 5'd0, 12'h300 + 4 * (i % 16));
      load(3'd2, 5'd17, 5'd0, 12'h300 + 4 * ((i * 7) % 16));
      op_rr(3'd0, 1'b0, 5'd16, 5'd16, 5'd17);
    end
    store(3'd2, 5'd16, 5'd0, 12'h340);
    check_state();
  endtask

  task automatic bus_error_test();
    start_test("bus_error");
    op_imm(3'd0, 5'd18, 5'd0, 12'h055);
    lui(5'd19, 20'h00001);
    load(3'd2, 5'd18, 5'd19, 12'h000);
    store(3'd2, 5'd18, 5'd0, 12'h3f0);
    store(3'd2, 5'd18, 5'd19, 12'h004);
    check_state();
  endtask

  task automatic x0_test();
    start_test("x0_unsupported");
    op_imm(3'd0, 5'd1, 5'd0, 12'h123);
    op_imm(3'd0, 5'd0, 5'd0, 12'h005);
    store(3'd2, 5'd0, 5'd0, 12'h3f4);
    // JAL x1 must retire without writing x1
    send(32'h008000ef);
    store(3'd2, 5'd1, 5'd0, 12'h3f8);
    check_state();
  endtask

  initial begin
    int n;
    inst_i <= '0;
    inst_valid_i <= 1'b0;
    wb_dat_i <= '0;
    wb_ack_i <= 1'b0;
    wb_err_i <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill(i);
      ref_mem[i] = fill(i);
    end
    for (int i = 0; i < 32; i++) rr[i] = '0;
    n = 0;
    @(posedge clk_i);
    while (rst_i && n < 50) begin
      @(posedge clk_i);
      n++;
    end
    assert (!rst_i) else begin
      $display("Reset never released");
      err_count++;
    end
    check_reset_outputs();
    @(posedge clk_i);
    alu_test();
    dependency_test();
    narrow_test();
    stall_test();
    bus_error_test();
    x0_test();
    $display("Errors: %0d", err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_operand_fetch.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_execute.sv
hdl/rv_core.sv
sim/tb_clock_gen.sv
sim/tb_rv_core.sv
